/* verilog/io_cmd_pkg.sv */
`default_nettype none

package io_cmd_pkg;

	// Host bus widths
	localparam int IO_W  = 16;
	localparam int CMD_W = 8;
	localparam int IDX_W = 4;

	typedef logic [IO_W-1:0]  io_word_t;
	typedef logic [CMD_W-1:0] cmd_t;
	typedef logic [IDX_W-1:0] word_idx_t;

	// Command codes, low byte of the first word in a frame
	localparam cmd_t CMD_VIDEO_MODE = 8'h20;
	localparam cmd_t CMD_VSET       = 8'h27;
	localparam cmd_t CMD_HSET       = 8'h37;
	localparam cmd_t CMD_ARC        = 8'h3A;
	localparam cmd_t CMD_STATUS     = 8'h40;

	// Reply to the video mode command word
	localparam io_word_t REPLY_MODE_OK = 16'd1;

endpackage

`default_nettype wire

/* verilog/video_pkg.sv */
`default_nettype none

package video_pkg;

	localparam int DIM_W = 12;

	// Pixel or line count
	typedef logic [DIM_W-1:0] dim_t;

	// Top bit set means an absolute size, not a ratio
	typedef logic [DIM_W:0] ar_coord_t;

	typedef struct packed {
		dim_t arx;
		dim_t ary;
		logic arxy;
	} aspect_t;

	// 1920x1080 until the host sends a mode
	localparam int DEF_WIDTH  = 1920;
	localparam int DEF_HEIGHT = 1080;

	// Operand and result width of the aspect multiply-divide
	localparam int MD_W = 12;

endpackage

`default_nettype wire

/* verilog/io_word_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface io_word_if import io_cmd_pkg::*; ();

	logic      strobe;
	logic      is_cmd;
	cmd_t      cmd;
	word_idx_t idx;
	io_word_t  data;
	// Synchronized select level
	logic      frame;

	modport rx (
		output strobe, is_cmd, cmd, idx, data, frame
	);

	modport regs (
		input strobe, is_cmd, cmd, idx, data, frame
	);

endinterface

`default_nettype wire

/* verilog/scaler_cfg_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface scaler_cfg_if import video_pkg::*; ();

	// Output mode
	dim_t      width;
	dim_t      height;
	logic      pixel_rep;

	// Limits and free scale
	dim_t      hset;
	dim_t      vset;
	logic      freescale;

	// Custom aspect ratios
	ar_coord_t arc1x;
	ar_coord_t arc1y;
	ar_coord_t arc2x;
	ar_coord_t arc2y;

	modport regs (
		output width, height, pixel_rep, hset, vset, freescale,
		output arc1x, arc1y, arc2x, arc2y
	);

	modport calc (
		input width, height, pixel_rep, hset, vset, freescale,
		input arc1x, arc1y, arc2x, arc2y
	);

endinterface

`default_nettype wire

/* verilog/io_cmd_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module io_cmd_rx import io_cmd_pkg::*; (
	input  wire           clk_sys,
	input  wire           resetd,
	input  wire io_word_t i_io_din,
	input  wire           i_io_clk,
	input  wire           i_io_ss,
	output logic          o_io_ack,
	io_word_if.rx         io_word
);

	io_word_t  din_meta, din_sync;
	logic      clk_meta, clk_sync, clk_dly;
	logic      ss_meta, ss_sync;
	logic      strobe;
	logic      has_cmd;
	cmd_t      cmd;
	word_idx_t cnt;

	//////////////////////////////////////////////////////////////////////
	// Bus synchronizer

	always_ff @(posedge clk_sys) begin
		din_meta <= i_io_din;
		din_sync <= din_meta;
	end

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			clk_meta <= 1'b0;
			clk_sync <= 1'b0;
			clk_dly  <= 1'b0;
			ss_meta  <= 1'b0;
			ss_sync  <= 1'b0;
			o_io_ack <= 1'b0;
		end else begin
			clk_meta <= i_io_clk;
			clk_sync <= clk_meta;
			clk_dly  <= clk_sync;
			ss_meta  <= i_io_ss;
			ss_sync  <= ss_meta;
			// Ack trails the edge by two cycles
			o_io_ack <= clk_dly;
		end
	end

	// One pulse per rising bus clock
	assign strobe = clk_sync & ~clk_dly;

	//////////////////////////////////////////////////////////////////////
	// Command framing

	always_ff @(posedge clk_sys) begin
		if (resetd || !ss_sync) begin
			has_cmd <= 1'b0;
			cmd     <= '0;
			cnt     <= '0;
		end else if (strobe) begin
			if (!has_cmd) begin
				has_cmd <= 1'b1;
				cmd     <= din_sync[CMD_W-1:0];
				cnt     <= '0;
			end else if (cnt != '1) begin
				// Saturates on long frames
				cnt <= cnt + 1'b1;
			end
		end
	end

	assign io_word.strobe = strobe;
	assign io_word.is_cmd = ~has_cmd;
	assign io_word.cmd    = cmd;
	assign io_word.idx    = cnt;
	assign io_word.data   = din_sync;
	assign io_word.frame  = ss_sync;

endmodule

`default_nettype wire

/* verilog/scaler_cfg_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module scaler_cfg_regs import io_cmd_pkg::*, video_pkg::*; (
	input  wire          clk_sys,
	input  wire          resetd,
	io_word_if.regs      io_word,
	input  wire aspect_t i_aspect,
	output io_word_t     o_io_dout,
	scaler_cfg_if.regs   cfg
);

	logic data_strobe;

	assign data_strobe = io_word.strobe & ~io_word.is_cmd;

	//////////////////////////////////////////////////////////////////////
	// Settings

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			cfg.width     <= dim_t'(DEF_WIDTH);
			cfg.height    <= dim_t'(DEF_HEIGHT);
			cfg.pixel_rep <= 1'b0;
			cfg.hset      <= '0;
			cfg.vset      <= '0;
			cfg.freescale <= 1'b0;
			cfg.arc1x     <= '0;
			cfg.arc1y     <= '0;
			cfg.arc2x     <= '0;
			cfg.arc2y     <= '0;
		end else if (data_strobe) begin
			case (io_word.cmd)
				CMD_VIDEO_MODE: begin
					// Only width, repeat bit and height are kept
					case (io_word.idx)
						4'd0: begin
							cfg.pixel_rep <= io_word.data[15];
							cfg.width     <= io_word.data[DIM_W-1:0];
						end
						4'd4: begin
							cfg.height <= io_word.data[DIM_W-1:0];
						end
						default: begin
						end
					endcase
				end
				CMD_VSET: begin
					cfg.vset <= io_word.data[DIM_W-1:0];
				end
				CMD_HSET: begin
					cfg.freescale <= io_word.data[15];
					cfg.hset      <= io_word.data[DIM_W-1:0];
				end
				CMD_ARC: begin
					case (io_word.idx)
						4'd0: cfg.arc1x <= io_word.data[DIM_W:0];
						4'd1: cfg.arc1y <= io_word.data[DIM_W:0];
						4'd2: cfg.arc2x <= io_word.data[DIM_W:0];
						4'd3: cfg.arc2y <= io_word.data[DIM_W:0];
						default: begin
						end
					endcase
				end
				default: begin
				end
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Reply word, ready before the ack rises

	always_ff @(posedge clk_sys) begin
		if (resetd || !io_word.frame) begin
			o_io_dout <= '0;
		end else if (io_word.strobe) begin
			o_io_dout <= '0;
			if (io_word.is_cmd) begin
				if (io_word.data[CMD_W-1:0] == CMD_VIDEO_MODE) begin
					o_io_dout <= REPLY_MODE_OK;
				end
			end else if (io_word.cmd == CMD_STATUS) begin
				// Resolved aspect, absolute flag at bit 12
				case (io_word.idx)
					4'd0: o_io_dout <= io_word_t'({i_aspect.arxy, i_aspect.arx});
					4'd1: o_io_dout <= io_word_t'({i_aspect.arxy, i_aspect.ary});
					default: begin
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/ar_muldiv.sv */
`timescale 1ns/1ps
`default_nettype none

module ar_muldiv import video_pkg::*; #(
	parameter int MD_W = video_pkg::MD_W
) (
	input  wire             clk_sys,
	input  wire             resetd,
	input  wire             i_start,
	input  wire [MD_W-1:0]  i_mul1,
	input  wire [MD_W-1:0]  i_mul2,
	input  wire [MD_W-1:0]  i_div,
	output logic            o_busy,
	output logic [MD_W-1:0] o_result
);

	localparam int CNT_W = $clog2(2 * MD_W);

	logic [MD_W-1:0]   mul_a, mul_b, div_d;
	logic [2*MD_W-1:0] quo;
	logic [MD_W:0]     rem, rem_shift;
	logic [CNT_W-1:0]  step;
	logic              mul_phase;

	// Next dividend bit enters the partial remainder
	assign rem_shift = {rem[MD_W-1:0], quo[2*MD_W-1]};

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_busy    <= 1'b0;
			mul_phase <= 1'b0;
			step      <= '0;
		end else if (i_start) begin
			o_busy    <= 1'b1;
			mul_phase <= 1'b1;
			mul_a     <= i_mul1;
			mul_b     <= i_mul2;
			div_d     <= i_div;
		end else if (mul_phase) begin
			mul_phase <= 1'b0;
			quo       <= {{MD_W{1'b0}}, mul_a} * {{MD_W{1'b0}}, mul_b};
			rem       <= '0;
			step      <= '0;
		end else if (o_busy) begin
			// Restoring division with one quotient bit per cycle
			if (rem_shift >= {1'b0, div_d}) begin
				rem <= rem_shift - {1'b0, div_d};
				quo <= {quo[2*MD_W-2:0], 1'b1};
			end else begin
				rem <= rem_shift;
				quo <= {quo[2*MD_W-2:0], 1'b0};
			end
			step <= step + 1'b1;
			if (step == CNT_W'(2 * MD_W - 1)) begin
				o_busy <= 1'b0;
			end
		end
	end

	assign o_result = quo[MD_W-1:0];

endmodule

`default_nettype wire

/* verilog/video_window_calc.sv */
`timescale 1ns/1ps
`default_nettype none

module video_window_calc import video_pkg::*; (
	input  wire            clk_sys,
	input  wire            resetd,
	scaler_cfg_if.calc     cfg,
	input  wire ar_coord_t i_arx,
	input  wire ar_coord_t i_ary,
	output aspect_t        o_aspect,
	output dim_t           o_hmin,
	output dim_t           o_hmax,
	output dim_t           o_vmin,
	output dim_t           o_vmax
);

	typedef enum logic [2:0] {
		ST_CHECK, ST_W_START, ST_W_WAIT, ST_H_START, ST_H_WAIT, ST_CLAMP, ST_CENTRE
	} state_t;

	state_t          state;
	dim_t            tgt_w, tgt_h;
	dim_t            wcalc, hcalc;
	dim_t            videow, videoh;
	logic            md_start, md_busy;
	logic [MD_W-1:0] md_mul1, md_mul2, md_div, md_result;

	//////////////////////////////////////////////////////////////////////
	// Target size and aspect selection

	always_ff @(posedge clk_sys) begin
		tgt_h <= (cfg.vset != '0 && cfg.vset < cfg.height) ? cfg.vset : cfg.height;
		tgt_w <= ((cfg.hset != '0 && cfg.hset < cfg.width) ? cfg.hset : cfg.width)
			<< cfg.pixel_rep;

		if (i_ary == '0) begin
			if (i_arx == ar_coord_t'(1)) begin
				o_aspect.arx  <= cfg.arc1x[DIM_W-1:0];
				o_aspect.ary  <= cfg.arc1y[DIM_W-1:0];
				o_aspect.arxy <= cfg.arc1x[DIM_W] | cfg.arc1y[DIM_W];
			end else if (i_arx == ar_coord_t'(2)) begin
				o_aspect.arx  <= cfg.arc2x[DIM_W-1:0];
				o_aspect.ary  <= cfg.arc2y[DIM_W-1:0];
				o_aspect.arxy <= cfg.arc2x[DIM_W] | cfg.arc2y[DIM_W];
			end else begin
				o_aspect <= '0;
			end
		end else begin
			o_aspect.arx  <= i_arx[DIM_W-1:0];
			o_aspect.ary  <= i_ary[DIM_W-1:0];
			o_aspect.arxy <= i_arx[DIM_W] | i_ary[DIM_W];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Window pass, repeats forever

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state    <= ST_CHECK;
			md_start <= 1'b0;
			o_hmin   <= '0;
			o_hmax   <= '0;
			o_vmin   <= '0;
			o_vmax   <= '0;
		end else begin
			md_start <= 1'b0;
			case (state)
				ST_CHECK: begin
					if (cfg.freescale || o_aspect.arx == '0 || o_aspect.ary == '0) begin
						wcalc <= tgt_w;
						hcalc <= tgt_h;
						state <= ST_CLAMP;
					end else if (o_aspect.arxy) begin
						wcalc <= o_aspect.arx;
						hcalc <= o_aspect.ary;
						state <= ST_CLAMP;
					end else begin
						state <= ST_W_START;
					end
				end
				ST_W_START: begin
					md_mul1  <= tgt_h;
					md_mul2  <= o_aspect.arx;
					md_div   <= o_aspect.ary;
					md_start <= 1'b1;
					state    <= ST_W_WAIT;
				end
				ST_W_WAIT: begin
					wcalc <= md_result;
					if (!md_start && !md_busy) begin
						state <= ST_H_START;
					end
				end
				ST_H_START: begin
					md_mul1  <= tgt_w;
					md_mul2  <= o_aspect.ary;
					md_div   <= o_aspect.arx;
					md_start <= 1'b1;
					state    <= ST_H_WAIT;
				end
				ST_H_WAIT: begin
					hcalc <= md_result;
					if (!md_start && !md_busy) begin
						state <= ST_CLAMP;
					end
				end
				ST_CLAMP: begin
					// Width back to source pixels when repeated
					videow <= (wcalc > tgt_w) ? (tgt_w >> cfg.pixel_rep) : (wcalc >> cfg.pixel_rep);
					videoh <= (hcalc > tgt_h) ? tgt_h : hcalc;
					state  <= ST_CENTRE;
				end
				ST_CENTRE: begin
					o_hmin <= (cfg.width - videow) >> 1;
					o_hmax <= ((cfg.width - videow) >> 1) + videow - 1'b1;
					o_vmin <= (cfg.height - videoh) >> 1;
					o_vmax <= ((cfg.height - videoh) >> 1) + videoh - 1'b1;
					state  <= ST_CHECK;
				end
				default: begin
					state <= ST_CHECK;
				end
			endcase
		end
	end

	ar_muldiv #(
		.MD_W (MD_W)
	) ar_muldiv_inst (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_start  (md_start),
		.i_mul1   (md_mul1),
		.i_mul2   (md_mul2),
		.i_div    (md_div),
		.o_busy   (md_busy),
		.o_result (md_result)
	);

endmodule

`default_nettype wire

/* verilog/scaler_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module scaler_ctrl_top import io_cmd_pkg::*, video_pkg::*; (
	input  wire            clk_sys,
	input  wire            resetd,
	input  wire io_word_t  i_io_din,
	input  wire            i_io_clk,
	input  wire            i_io_ss,
	// Aspect request from the core
	input  wire ar_coord_t i_arx,
	input  wire ar_coord_t i_ary,
	output io_word_t       o_io_dout,
	output logic           o_io_ack,
	output dim_t           o_hmin,
	output dim_t           o_hmax,
	output dim_t           o_vmin,
	output dim_t           o_vmax
);

	io_word_if    io_word ();
	scaler_cfg_if scaler_cfg ();
	aspect_t      aspect;

	io_cmd_rx io_cmd_rx_inst (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_io_din (i_io_din),
		.i_io_clk (i_io_clk),
		.i_io_ss  (i_io_ss),
		.o_io_ack (o_io_ack),
		.io_word  (io_word.rx)
	);

	scaler_cfg_regs scaler_cfg_regs_inst (
		.clk_sys   (clk_sys),
		.resetd    (resetd),
		.io_word   (io_word.regs),
		.i_aspect  (aspect),
		.o_io_dout (o_io_dout),
		.cfg       (scaler_cfg.regs)
	);

	video_window_calc video_window_calc_inst (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.cfg      (scaler_cfg.calc),
		.i_arx    (i_arx),
		.i_ary    (i_ary),
		.o_aspect (aspect),
		.o_hmin   (o_hmin),
		.o_hmax   (o_hmax),
		.o_vmin   (o_vmin),
		.o_vmax   (o_vmax)
	);

endmodule

`default_nettype wire

/* dv/tb_scaler_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_scaler_ctrl import io_cmd_pkg::*, video_pkg::*; ();

	localparam int WAIT_LIMIT = 2000;

	logic      clk_sys;
	logic      resetd;
	io_word_t  i_io_din;
	logic      i_io_clk;
	logic      i_io_ss;
	ar_coord_t i_arx;
	ar_coord_t i_ary;
	io_word_t  o_io_dout;
	logic      o_io_ack;
	dim_t      o_hmin, o_hmax, o_vmin, o_vmax;

	int        value_errors;
	int        timeout_errors;

	// Host side copy of the settings
	int        m_width, m_height, m_rep, m_hset, m_vset, m_fs;
	int        m_req_x, m_req_y;
	int        m_arc [4];

	io_word_t  payload [$];
	io_word_t  replies [$];
	io_word_t  cmd_reply;
	logic      cmd_ack_held;

	scaler_ctrl_top scaler_ctrl_top_inst (
		.clk_sys   (clk_sys),
		.resetd    (resetd),
		.i_io_din  (i_io_din),
		.i_io_clk  (i_io_clk),
		.i_io_ss   (i_io_ss),
		.i_arx     (i_arx),
		.i_ary     (i_ary),
		.o_io_dout (o_io_dout),
		.o_io_ack  (o_io_ack),
		.o_hmin    (o_hmin),
		.o_hmax    (o_hmax),
		.o_vmin    (o_vmin),
		.o_vmax    (o_vmax)
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	//////////////////////////////////////////////////////////////////////
	// Host bus

	// Drive and sample point 1 ns after the rising edge
	task automatic tick();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic send_word(input io_word_t word, output io_word_t reply, output logic ack_held);
		int n;
		i_io_din = word;
		i_io_clk = 1'b1;
		n = 0;
		tick();
		while (!o_io_ack && n < WAIT_LIMIT) begin
			tick();
			n++;
		end
		if (!o_io_ack) begin
			$display("timeout at %0t: no acknowledge for host word %h", $time, word);
			timeout_errors++;
		end
		reply = o_io_dout;
		i_io_clk = 1'b0;
		tick();
		ack_held = o_io_ack;
		n = 0;
		while (o_io_ack && n < WAIT_LIMIT) begin
			tick();
			n++;
		end
		if (o_io_ack) begin
			$display("timeout at %0t: acknowledge stays high after bus clock fell", $time);
			timeout_errors++;
		end
	endtask

	// Command word followed by every word in payload
	task automatic send_cmd(input cmd_t cmd);
		io_word_t reply;
		logic     held;
		i_io_ss = 1'b1;
		tick();
		tick();
		send_word(io_word_t'(cmd), cmd_reply, cmd_ack_held);
		replies.delete();
		foreach (payload[i]) begin
			send_word(payload[i], reply, held);
			replies.push_back(reply);
		end
		i_io_ss = 1'b0;
		repeat (4) tick();
	endtask

	task automatic set_mode(input int w, input int h, input int rep);
		payload.delete();
		payload.push_back(io_word_t'(w) | (rep != 0 ? 16'h8000 : 16'h0000));
		repeat (3) payload.push_back('0);
		payload.push_back(io_word_t'(h));
		send_cmd(CMD_VIDEO_MODE);
		m_width  = w;
		m_height = h;
		m_rep    = rep;
	endtask

	task automatic set_vset(input int v);
		payload.delete();
		payload.push_back(io_word_t'(v));
		send_cmd(CMD_VSET);
		m_vset = v;
	endtask

	task automatic set_hset(input int h, input int fs);
		payload.delete();
		payload.push_back(io_word_t'(h) | (fs != 0 ? 16'h8000 : 16'h0000));
		send_cmd(CMD_HSET);
		m_hset = h;
		m_fs   = fs;
	endtask

	task automatic set_arc(input int a1x, input int a1y, input int a2x, input int a2y);
		payload.delete();
		payload.push_back(io_word_t'(a1x));
		payload.push_back(io_word_t'(a1y));
		payload.push_back(io_word_t'(a2x));
		payload.push_back(io_word_t'(a2y));
		send_cmd(CMD_ARC);
		m_arc[0] = a1x;
		m_arc[1] = a1y;
		m_arc[2] = a2x;
		m_arc[3] = a2y;
	endtask

	task automatic set_request(input int x, input int y);
		i_arx   = ar_coord_t'(x);
		i_ary   = ar_coord_t'(y);
		m_req_x = x;
		m_req_y = y;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Expected window

	function automatic void window_model(output int hmin, output int hmax,
		output int vmin, output int vmax);
		int tgt_w, tgt_h, ax, ay, abs_flag, pw, ph;
		tgt_h = (m_vset != 0 && m_vset < m_height) ? m_vset : m_height;
		tgt_w = (m_hset != 0 && m_hset < m_width) ? m_hset : m_width;
		tgt_w = (m_rep != 0) ? tgt_w * 2 : tgt_w;
		ax = m_req_x;
		ay = m_req_y;
		if (m_req_y == 0) begin
			ax = (m_req_x == 1) ? m_arc[0] : (m_req_x == 2) ? m_arc[2] : 0;
			ay = (m_req_x == 1) ? m_arc[1] : (m_req_x == 2) ? m_arc[3] : 0;
		end
		abs_flag = ((ax | ay) >> 12) & 1;
		ax = ax % 4096;
		ay = ay % 4096;
		if (m_fs != 0 || ax == 0 || ay == 0) begin
			pw = tgt_w;
			ph = tgt_h;
		end else if (abs_flag != 0) begin
			pw = ax;
			ph = ay;
		end else begin
			pw = tgt_h * ax / ay;
			ph = tgt_w * ay / ax;
		end
		pw = (pw > tgt_w) ? tgt_w : pw;
		ph = (ph > tgt_h) ? tgt_h : ph;
		pw = (m_rep != 0) ? pw / 2 : pw;
		hmin = (m_width - pw) / 2;
		hmax = hmin + pw - 1;
		vmin = (m_height - ph) / 2;
		vmax = vmin + ph - 1;
	endfunction

	function automatic logic window_is(input int h0, input int h1, input int v0, input int v1);
		return int'(o_hmin) == h0 && int'(o_hmax) == h1 && int'(o_vmin) == v0
			&& int'(o_vmax) == v1;
	endfunction

	// Waits for the window to reach the expected value
	task automatic check_window(input string name);
		int h0, h1, v0, v1, n;
		window_model(h0, h1, v0, v1);
		n = 0;
		while (!window_is(h0, h1, v0, v1) && n < WAIT_LIMIT) begin
			tick();
			n++;
		end
		if (!window_is(h0, h1, v0, v1)) begin
			$display("error at %0t: %s window %0d-%0d x %0d-%0d, expected %0d-%0d x %0d-%0d",
				$time, name, o_hmin, o_hmax, o_vmin, o_vmax, h0, h1, v0, v1);
			value_errors++;
		end
	endtask

	task automatic check_word(input string name, input io_word_t got, input io_word_t exp);
		if (got !== exp) begin
			$display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
			value_errors++;
		end
	endtask

	// Status read of the resolved aspect
	task automatic check_status(input string name, input int exp_x, input int exp_y);
		payload.delete();
		payload.push_back('0);
		payload.push_back('0);
		send_cmd(CMD_STATUS);
		check_word({name, " arx"}, replies[0], io_word_t'(exp_x));
		check_word({name, " ary"}, replies[1], io_word_t'(exp_y));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests

	task automatic test_reset();
		if (o_io_ack !== 1'b0) begin
			$display("error at %0t: acknowledge high after reset", $time);
			value_errors++;
		end
		check_word("dout after reset", o_io_dout, '0);
		check_window("reset default");
	endtask

	task automatic test_mode();
		set_mode(1280, 720, 0);
		check_word("mode reply", cmd_reply, REPLY_MODE_OK);
		if (cmd_ack_held !== 1'b1) begin
			$display("error at %0t: acknowledge fell together with the bus clock", $time);
			value_errors++;
		end
		check_window("mode 1280x720");
	endtask

	task automatic test_limits();
		set_vset(600);
		check_window("vset 600");
		set_hset(1000, 0);
		check_window("hset 1000");
	endtask

	task automatic test_aspect();
		set_vset(0);
		set_hset(0, 0);
		set_mode(1920, 1080, 0);
		set_request(4, 3);
		check_window("aspect 4:3");
		set_hset(0, 1);
		check_window("freescale");
		set_hset(0, 0);
	endtask

	task automatic test_custom();
		set_arc(16, 9, 'h1000 | 800, 600);
		set_request(1, 0);
		check_status("status custom 1", 16, 9);
		check_window("custom 16:9");
		set_request(2, 0);
		// Absolute flag shows at bit 12 of both words
		check_status("status custom 2", 'h1000 | 800, 'h1000 | 600);
		check_window("custom absolute 800x600");
	endtask

	task automatic test_pixel_rep();
		set_mode(960, 1080, 1);
		set_request(4, 3);
		check_window("pixel repeat 4:3");
		set_request(0, 0);
		check_window("pixel repeat full");
	endtask

	initial begin
		resetd   = 1'b1;
		i_io_din = '0;
		i_io_clk = 1'b0;
		i_io_ss  = 1'b0;
		i_arx    = '0;
		i_ary    = '0;
		value_errors   = 0;
		timeout_errors = 0;
		m_width  = DEF_WIDTH;
		m_height = DEF_HEIGHT;
		m_rep    = 0;
		m_hset   = 0;
		m_vset   = 0;
		m_fs     = 0;
		m_req_x  = 0;
		m_req_y  = 0;
		m_arc    = '{default: 0};
		repeat (5) @(posedge clk_sys);
		#1;
		resetd = 1'b0;
		tick();
		test_reset();
		test_mode();
		test_limits();
		test_aspect();
		test_custom();
		test_pixel_rep();
		$display("value errors %0d, timeouts %0d", value_errors, timeout_errors);
		if (value_errors == 0 && timeout_errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
verilog/io_cmd_pkg.sv
verilog/video_pkg.sv
verilog/io_word_if.sv
verilog/scaler_cfg_if.sv
verilog/io_cmd_rx.sv
verilog/scaler_cfg_regs.sv
verilog/ar_muldiv.sv
verilog/video_window_calc.sv
verilog/scaler_ctrl_top.sv
dv/tb_scaler_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the scaler control testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f files.f --top-module tb_scaler_ctrl -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

echo "$out" | grep -qx "sim passed"
